/* common/fp_defs.svh */
`ifndef FP_DEFS_SVH
`define FP_DEFS_SVH

// ==========================================================
// Number format
// ==========================================================
// Sign, biased exponent, fraction with hidden one
`define FP_W        27
`define FP_EXP_W    8
`define FP_FRAC_W   18
`define FP_BIAS     127

// Signed integer side of the converters
`define INT_W       16
`define INT_MAX     16'h7FFF

// ==========================================================
// APB and register map
// ==========================================================
`define APB_ADDR_W  8
`define APB_DATA_W  32

`define REG_OPA     8'h00
`define REG_OPB     8'h04
`define REG_CMD     8'h08
`define REG_STATUS  8'h0C
`define REG_RESULT  8'h10

// Opcode field width in REG_CMD
`define OP_W        3

// Adder pipeline depth
`define ADD_LAT     2

`endif

/* common/fp_pkg.sv */
`include "fp_defs.svh"

package fp_pkg;

	// ==========================================================
	// Data words
	// ==========================================================
	// Full float word
	typedef logic [`FP_W-1:0]       fp27_t;
	// Biased exponent field
	typedef logic [`FP_EXP_W-1:0]   fp_exp_t;
	// Stored fraction, hidden one not included
	typedef logic [`FP_FRAC_W-1:0]  fp_frac_t;
	// Two's complement integer
	typedef logic signed [`INT_W-1:0] int16_t;

	// Bus words
	typedef logic [`APB_ADDR_W-1:0] apb_addr_t;
	typedef logic [`APB_DATA_W-1:0] apb_data_t;

	// ==========================================================
	// Enums
	// ==========================================================
	// Opcodes as written to REG_CMD
	typedef enum logic [`OP_W-1:0] {
		OP_ADD = 3'd0,
		OP_MUL = 3'd1,
		OP_I2F = 3'd2,
		OP_F2I = 3'd3,
		OP_CMP = 3'd4,
		OP_NEG = 3'd5
	} fp_op_e;

	// Sequencer states
	typedef enum logic [1:0] {
		EXEC_IDLE,
		EXEC_WAIT,
		EXEC_DONE
	} exec_state_e;

endpackage

/* fp_unit/fp_add.sv */
`timescale 1ns/10ps
`include "fp_defs.svh"

module fp_add import fp_pkg::*; (
	input  logic  iCLK,
	input  logic  rst_n,
	input  fp27_t a,
	input  fp27_t b,
	output fp27_t sum
);

	// Mantissa with hidden one
	localparam int MAN_W = `FP_FRAC_W + 1;
	// Carry bit, mantissa, guard bits below
	localparam int AL_W  = 2 * `FP_FRAC_W + 2;
	// Hidden one position when no carry
	localparam int HID   = AL_W - 2;
	localparam int POS_W = $clog2(AL_W);

	logic              a_s, b_s;
	fp_exp_t           a_e, b_e;
	fp_frac_t          a_f, b_f;
	logic              a_larger;
	fp_exp_t           diff;
	fp_exp_t           big_e;
	logic [MAN_W-1:0]  small_m;
	logic [AL_W-1:0]   big_al, small_al;
	logic [AL_W-1:0]   pre_sum;

	logic [AL_W-1:0]   s1_sum;
	fp_exp_t           s1_exp;
	logic              s1_sign;
	fp27_t             s1_a, s1_b;
	logic              s1_a_zero, s1_b_zero;

	logic [POS_W-1:0]  lead;
	logic [AL_W-1:0]   norm;
	logic [9:0]        e_tmp;
	logic              underflow;

	// Highest set bit, zero when none
	function automatic logic [POS_W-1:0] lead_one(input logic [AL_W-1:0] v);
		logic [POS_W-1:0] p;
		p = '0;
		for (int i = 0; i < AL_W; i++) begin
			if (v[i]) begin
				p = POS_W'(i);
			end
		end
		return p;
	endfunction

	// ==========================================================
	// Stage 1 align and add
	// ==========================================================
	assign a_s = a[`FP_W-1];
	assign a_e = a[`FP_W-2 -: `FP_EXP_W];
	assign a_f = a[`FP_FRAC_W-1:0];
	assign b_s = b[`FP_W-1];
	assign b_e = b[`FP_W-2 -: `FP_EXP_W];
	assign b_f = b[`FP_FRAC_W-1:0];

	// Equal magnitudes pick b as the larger
	assign a_larger = (a_e > b_e) || ((a_e == b_e) && (a_f > b_f));
	assign diff     = a_larger ? (a_e - b_e) : (b_e - a_e);
	assign big_e    = a_larger ? a_e : b_e;
	assign small_m  = a_larger ? {1'b1, b_f} : {1'b1, a_f};

	// Larger operand never shifts
	assign big_al = a_larger ? {1'b0, 1'b1, a_f, {(AL_W-MAN_W-1){1'b0}}} :
		{1'b0, 1'b1, b_f, {(AL_W-MAN_W-1){1'b0}}};
	// Shifted past the guard bits gives nothing
	assign small_al = (diff >= AL_W) ? '0 :
		({1'b0, small_m, {(AL_W-MAN_W-1){1'b0}}} >> diff);

	// Unlike signs subtract the smaller magnitude
	assign pre_sum = (a_s ^ b_s) ? (big_al - small_al) : (big_al + small_al);

	// Zero operand flags for the pass-through
	always_ff @(posedge iCLK or negedge rst_n) begin
		if (!rst_n) begin
			s1_a_zero <= 1'b0;
			s1_b_zero <= 1'b0;
		end else begin
			s1_a_zero <= (a_e == '0);
			s1_b_zero <= (b_e == '0);
		end
	end

	always_ff @(posedge iCLK) begin
		s1_sum  <= pre_sum;
		s1_exp  <= big_e;
		s1_sign <= a_larger ? a_s : b_s;
		s1_a    <= a;
		s1_b    <= b;
	end

	// ==========================================================
	// Stage 2 normalize
	// ==========================================================
	assign lead = lead_one(s1_sum);
	// Leading one moves to the top bit and drops as the hidden one
	assign norm = s1_sum << (POS_W'(AL_W - 1) - lead);

	// Exponent moves by the lead offset from HID
	assign e_tmp     = {2'b0, s1_exp} + 10'(lead);
	assign underflow = (e_tmp <= 10'(HID));

	always_ff @(posedge iCLK or negedge rst_n) begin
		if (!rst_n) begin
			sum <= '0;
		end else if (s1_a_zero && s1_b_zero) begin
			sum <= '0;
		end else if (s1_a_zero) begin
			sum <= s1_b;
		end else if (s1_b_zero) begin
			sum <= s1_a;
		end else if ((s1_sum == '0) || underflow) begin
			// Full cancel or exponent below range
			sum <= '0;
		end else begin
			sum <= {s1_sign, fp_exp_t'(e_tmp - 10'(HID)), norm[AL_W-2 -: `FP_FRAC_W]};
		end
	end

endmodule

/* fp_unit/fp_convert.sv */
`timescale 1ns/10ps
`include "fp_defs.svh"

module fp_convert import fp_pkg::*; (
	input  int16_t int_in,
	input  fp27_t  fp_in,
	output fp27_t  fp_out,
	output int16_t int_out
);

	// Room for a 16-bit integer above the fraction
	localparam int SH_W  = `FP_FRAC_W + `INT_W;
	localparam int POS_W = $clog2(`INT_W);

	logic              i_s;
	logic [`INT_W-1:0] i_mag;
	logic [POS_W-1:0]  i_lead;
	logic [SH_W-1:0]   i_sh;

	logic              f_s;
	fp_exp_t           f_e;
	logic [SH_W-1:0]   f_sh;
	int16_t            f_mag;

	// ==========================================================
	// Integer to float
	// ==========================================================
	assign i_s   = int_in[`INT_W-1];
	// Most negative value wraps to its own magnitude
	assign i_mag = i_s ? -int_in : int_in;

	// Leading one search
	always_comb begin
		i_lead = '0;
		for (int i = 0; i < `INT_W; i++) begin
			if (i_mag[i]) begin
				i_lead = POS_W'(i);
			end
		end
	end

	// Leading one lands on the hidden bit position
	assign i_sh   = SH_W'(i_mag) << (`FP_FRAC_W - i_lead);
	assign fp_out = (int_in == '0) ? '0 :
		{i_s, fp_exp_t'(`FP_BIAS + i_lead), i_sh[`FP_FRAC_W-1:0]};

	// ==========================================================
	// Float to integer
	// ==========================================================
	assign f_s = fp_in[`FP_W-1];
	assign f_e = fp_in[`FP_W-2 -: `FP_EXP_W];

	// 1.f shifted up by the unbiased exponent
	assign f_sh  = SH_W'({1'b1, fp_in[`FP_FRAC_W-1:0]}) << (f_e - fp_exp_t'(`FP_BIAS));
	// Integer part only, truncates toward zero
	assign f_mag = f_sh[SH_W-1 -: `INT_W];

	always_comb begin
		if (f_e < fp_exp_t'(`FP_BIAS)) begin
			// Magnitude below one
			int_out = '0;
		end else if (f_e > fp_exp_t'(`FP_BIAS + `INT_W - 2)) begin
			// Clip on overflow
			int_out = f_s ? -int16_t'(`INT_MAX) : int16_t'(`INT_MAX);
		end else begin
			int_out = f_s ? -f_mag : f_mag;
		end
	end

endmodule

/* fp_unit/fp_exec.sv */
`timescale 1ns/10ps
`include "fp_defs.svh"

module fp_exec import fp_pkg::*; (
	input  logic      iCLK,
	input  logic      rst_n,
	input  logic      start,
	input  fp_op_e    op,
	input  fp27_t     opa,
	input  fp27_t     opb,
	output logic      busy,
	output logic      done,
	output apb_data_t result
);

	localparam int CNT_W = $clog2(`ADD_LAT + 1);

	exec_state_e      state;
	fp_op_e           op_q;
	fp_op_e           sel_op;
	logic [CNT_W-1:0] cnt;

	fp27_t            add_sum, mul_prod, i2f_out, neg_out;
	int16_t           f2i_out;
	logic             a_mag_ge, cmp_ge;
	apb_data_t        unit_result;

	// ==========================================================
	// Units
	// ==========================================================
	fp_add u_add (
		.iCLK (iCLK),
		.rst_n(rst_n),
		.a    (opa),
		.b    (opb),
		.sum  (add_sum)
	);

	fp_mul u_mul (
		.a   (opa),
		.b   (opb),
		.prod(mul_prod)
	);

	// Integer operand from the low half of A
	fp_convert u_conv (
		.int_in (int16_t'(opa[`INT_W-1:0])),
		.fp_in  (opa),
		.fp_out (i2f_out),
		.int_out(f2i_out)
	);

	// Flip the sign bit only
	assign neg_out = {~opa[`FP_W-1], opa[`FP_W-2:0]};

	// Magnitude test, exponent then fraction
	assign a_mag_ge = (opa[`FP_W-2 -: `FP_EXP_W] > opb[`FP_W-2 -: `FP_EXP_W]) ||
		((opa[`FP_W-2 -: `FP_EXP_W] == opb[`FP_W-2 -: `FP_EXP_W]) &&
		(opa[`FP_FRAC_W-1:0] >= opb[`FP_FRAC_W-1:0]));

	// Sign decides first, both negative inverts
	always_comb begin
		case ({opa[`FP_W-1], opb[`FP_W-1]})
			2'b01:   cmp_ge = 1'b1;
			2'b10:   cmp_ge = 1'b0;
			2'b00:   cmp_ge = a_mag_ge;
			default: cmp_ge = ~a_mag_ge;
		endcase
	end

	// ==========================================================
	// Result select
	// ==========================================================
	// Incoming opcode at start, latched one while waiting
	assign sel_op = (state == EXEC_WAIT) ? op_q : op;

	always_comb begin
		case (sel_op)
			OP_ADD:  unit_result = {{(`APB_DATA_W-`FP_W){1'b0}}, add_sum};
			OP_MUL:  unit_result = {{(`APB_DATA_W-`FP_W){1'b0}}, mul_prod};
			OP_I2F:  unit_result = {{(`APB_DATA_W-`FP_W){1'b0}}, i2f_out};
			// Sign extended integer
			OP_F2I:  unit_result = {{(`APB_DATA_W-`INT_W){f2i_out[`INT_W-1]}}, f2i_out};
			OP_CMP:  unit_result = {{(`APB_DATA_W-1){1'b0}}, cmp_ge};
			OP_NEG:  unit_result = {{(`APB_DATA_W-`FP_W){1'b0}}, neg_out};
			default: unit_result = '0;
		endcase
	end

	// ==========================================================
	// Sequencer FSM
	// ==========================================================
	always_ff @(posedge iCLK or negedge rst_n) begin
		if (!rst_n) begin
			state  <= EXEC_IDLE;
			op_q   <= OP_ADD;
			cnt    <= '0;
			result <= '0;
		end else begin
			case (state)
				EXEC_WAIT: begin
					// Adder output valid on the last count
					if (cnt == CNT_W'(1)) begin
						result <= unit_result;
						state  <= EXEC_DONE;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				default: begin
					// Idle and done both accept a start
					if (start) begin
						op_q <= op;
						if (op == OP_ADD) begin
							cnt   <= CNT_W'(`ADD_LAT);
							state <= EXEC_WAIT;
						end else begin
							// Combinational units finish now
							result <= unit_result;
							state  <= EXEC_DONE;
						end
					end
				end
			endcase
		end
	end

	// Busy from the start pulse until capture
	assign busy = start | (state == EXEC_WAIT);
	// New command clears done at once
	assign done = (state == EXEC_DONE) & ~start;

endmodule

/* fp_unit/fp_mul.sv */
`timescale 1ns/10ps
`include "fp_defs.svh"

module fp_mul import fp_pkg::*; (
	input  fp27_t a,
	input  fp27_t b,
	output fp27_t prod
);

	localparam int MAN_W = `FP_FRAC_W + 1;
	localparam int PRD_W = 2 * MAN_W;

	fp_exp_t            a_e, b_e;
	logic [PRD_W-1:0]   prod_m;
	logic [`FP_EXP_W:0] e_sum;
	logic               top;
	logic [`FP_EXP_W:0] p_e;
	fp_frac_t           p_f;
	logic               underflow;

	assign a_e = a[`FP_W-2 -: `FP_EXP_W];
	assign b_e = b[`FP_W-2 -: `FP_EXP_W];

	// Full mantissa product, two integer bits on top
	assign prod_m = {1'b1, a[`FP_FRAC_W-1:0]} * {1'b1, b[`FP_FRAC_W-1:0]};
	assign e_sum  = {1'b0, a_e} + {1'b0, b_e};

	// Product in [2,4) bumps the exponent
	assign top = prod_m[PRD_W-1];
	assign p_e = top ? (e_sum - 9'(`FP_BIAS - 1)) : (e_sum - 9'(`FP_BIAS));
	assign p_f = top ? prod_m[PRD_W-2 -: `FP_FRAC_W] : prod_m[PRD_W-3 -: `FP_FRAC_W];

	// Biased sum too small for a normal result
	assign underflow = (e_sum < 9'(`FP_BIAS + 1));

	// Zero operand or underflow flushes to zero
	assign prod = (underflow || (a_e == '0) || (b_e == '0)) ? '0 :
		{a[`FP_W-1] ^ b[`FP_W-1], p_e[`FP_EXP_W-1:0], p_f};

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -Wno-fatal --top-module tb_fp_apb -f tb.f -Mdir obj_dir -o tb_fp_apb
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/tb_fp_apb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
	exit 1
fi
if ! grep -q "TB PASSED" "$LOG"; then
	echo "No pass message in $LOG"
	exit 1
fi
exit 0

/* src/apb_regs.sv */
`timescale 1ns/10ps
`include "fp_defs.svh"

module apb_regs import fp_pkg::*; (
	input  logic      iCLK,
	input  logic      rst_n,
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  apb_addr_t paddr,
	input  apb_data_t pwdata,
	input  logic      busy,
	input  logic      done,
	input  apb_data_t result,
	output apb_data_t prdata,
	output logic      pready,
	output logic      pslverr,
	output logic      start,
	output fp_op_e    op,
	output fp27_t     opa,
	output fp27_t     opb
);

	logic access;
	logic wr_en;
	logic hit_opa, hit_opb, hit_cmd, hit_status, hit_result;
	logic mapped;
	logic cmd_legal;
	logic cmd_ok;

	// ==========================================================
	// Access decode
	// ==========================================================
	// Access phase only, setup phase does nothing
	assign access = psel & penable;
	assign wr_en  = access & pwrite;

	assign hit_opa    = (paddr == `REG_OPA);
	assign hit_opb    = (paddr == `REG_OPB);
	assign hit_cmd    = (paddr == `REG_CMD);
	assign hit_status = (paddr == `REG_STATUS);
	assign hit_result = (paddr == `REG_RESULT);
	assign mapped = hit_opa | hit_opb | hit_cmd | hit_status | hit_result;

	// Opcode must fit the enum, upper bits zero
	assign cmd_legal = (pwdata[`APB_DATA_W-1:`OP_W] == '0) &&
		(pwdata[`OP_W-1:0] <= OP_NEG);
	// Accepted command, single check point for busy and opcode
	assign cmd_ok = wr_en & hit_cmd & ~busy & cmd_legal;

	// Zero wait states
	assign pready = 1'b1;
	// Unmapped address, or a rejected command
	assign pslverr = access & (~mapped | (pwrite & hit_cmd & (busy | ~cmd_legal)));

	// ==========================================================
	// Registers
	// ==========================================================
	always_ff @(posedge iCLK or negedge rst_n) begin
		if (!rst_n) begin
			opa   <= '0;
			opb   <= '0;
			op    <= OP_ADD;
			start <= 1'b0;
		end else begin
			// One-cycle pulse after the accepting edge
			start <= cmd_ok;
			if (wr_en && hit_opa) begin
				opa <= pwdata[`FP_W-1:0];
			end
			if (wr_en && hit_opb) begin
				opb <= pwdata[`FP_W-1:0];
			end
			if (cmd_ok) begin
				op <= fp_op_e'(pwdata[`OP_W-1:0]);
			end
		end
	end

	// ==========================================================
	// Read mux
	// ==========================================================
	// Register values from the prior edge
	always_comb begin
		prdata = '0;
		if (hit_opa) begin
			prdata = {{(`APB_DATA_W-`FP_W){1'b0}}, opa};
		end else if (hit_opb) begin
			prdata = {{(`APB_DATA_W-`FP_W){1'b0}}, opb};
		end else if (hit_cmd) begin
			prdata = {{(`APB_DATA_W-`OP_W){1'b0}}, op};
		end else if (hit_status) begin
			// Bit 1 done, bit 0 busy
			prdata = {{(`APB_DATA_W-2){1'b0}}, done, busy};
		end else if (hit_result) begin
			prdata = result;
		end
	end

endmodule

/* src/fp_apb_top.sv */
`timescale 1ns/10ps

module fp_apb_top import fp_pkg::*; (
	input  logic      iCLK,
	input  logic      rst_n,
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  apb_addr_t paddr,
	input  apb_data_t pwdata,
	output apb_data_t prdata,
	output logic      pready,
	output logic      pslverr
);

	// Register block to sequencer
	logic      start;
	fp_op_e    op;
	fp27_t     opa, opb;
	// Sequencer back to register block
	logic      busy, done;
	apb_data_t result;

	apb_regs u_regs (
		.iCLK   (iCLK),
		.rst_n  (rst_n),
		.psel   (psel),
		.penable(penable),
		.pwrite (pwrite),
		.paddr  (paddr),
		.pwdata (pwdata),
		.busy   (busy),
		.done   (done),
		.result (result),
		.prdata (prdata),
		.pready (pready),
		.pslverr(pslverr),
		.start  (start),
		.op     (op),
		.opa    (opa),
		.opb    (opb)
	);

	fp_exec u_exec (
		.iCLK  (iCLK),
		.rst_n (rst_n),
		.start (start),
		.op    (op),
		.opa   (opa),
		.opb   (opb),
		.busy  (busy),
		.done  (done),
		.result(result)
	);

endmodule

/* tb.f */
+incdir+common
common/fp_pkg.sv
src/apb_regs.sv
fp_unit/fp_add.sv
fp_unit/fp_mul.sv
fp_unit/fp_convert.sv
fp_unit/fp_exec.sv
src/fp_apb_top.sv
verif/tb_fp_apb.sv

/* verif/tb_fp_apb.sv */
`timescale 1ns/10ps
`include "fp_defs.svh"

module tb_fp_apb import fp_pkg::*; ();

	localparam int RESET_CYCLES = 10;
	localparam int N_FIXED      = 15;
	localparam int N_RAND       = 4;
	localparam int N_ROWS       = N_FIXED + 2 * N_RAND;
	localparam int N_PROTO      = 3;
	// 40 cycles for each table row and protocol test
	localparam int MAX_CYCLES   = 40 * (N_ROWS + N_PROTO) + RESET_CYCLES;

	logic      iCLK, rst_n;
	logic      psel, penable, pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata, prdata;
	logic      pready, pslverr;

	// Stimulus table
	fp_op_e    row_op  [N_ROWS];
	fp27_t     row_a   [N_ROWS];
	fp27_t     row_b   [N_ROWS];
	apb_data_t row_exp [N_ROWS];

	int          errors, pass_count, fail_count;
	int          cycles = 0;
	logic        test_ok;
	logic [31:0] lcg_state;

	fp_apb_top dut0 (
		.iCLK   (iCLK),
		.rst_n  (rst_n),
		.psel   (psel),
		.penable(penable),
		.pwrite (pwrite),
		.paddr  (paddr),
		.pwdata (pwdata),
		.prdata (prdata),
		.pready (pready),
		.pslverr(pslverr)
	);

	initial begin
		iCLK = 1'b0;
		forever #4 iCLK = ~iCLK;
	end

	// Run limit
	always @(posedge iCLK) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, DUT never reported done", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	// ==========================================================
	// Reference helpers
	// ==========================================================
	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic fp27_t fp_make(input logic s, input int e, input fp_frac_t f);
		return {s, fp_exp_t'(e), f};
	endfunction

	// Value 2^k * (1 + f) straight from the format
	function automatic fp27_t int_to_fp(input int v);
		int          mag;
		int          k;
		logic [63:0] scaled;
		if (v == 0) begin
			return '0;
		end
		mag = (v < 0) ? -v : v;
		k = 0;
		while ((mag >> (k + 1)) != 0) begin
			k++;
		end
		// Hidden one falls off above the fraction
		scaled = (64'(mag) << `FP_FRAC_W) >> k;
		return {v < 0, fp_exp_t'(`FP_BIAS + k), scaled[`FP_FRAC_W-1:0]};
	endfunction

	// ==========================================================
	// Checks
	// ==========================================================
	task automatic check_fp(input string name, input fp27_t exp, input fp27_t got);
		if (got !== exp) begin
			$display("Error %s expected %h got %h", name, exp, got);
			errors++;
			test_ok = 1'b0;
		end
	endtask

	task automatic check_int(input string name, input int16_t exp, input int16_t got);
		if (got !== exp) begin
			$display("Error %s expected %h got %h", name, exp, got);
			errors++;
			test_ok = 1'b0;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			$display("Error %s expected %h got %h", name, exp, got);
			errors++;
			test_ok = 1'b0;
		end
	endtask

	task automatic check_data(input string name, input apb_data_t exp, input apb_data_t got);
		if (got !== exp) begin
			$display("Error %s expected %h got %h", name, exp, got);
			errors++;
			test_ok = 1'b0;
		end
	endtask

	task automatic report_test(input string name);
		if (test_ok) begin
			pass_count++;
			$display("%s: pass", name);
		end else begin
			fail_count++;
			$display("%s: fail", name);
		end
	endtask

	// ==========================================================
	// APB transfers
	// ==========================================================
	// Setup, access, then one idle cycle
	task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
		@(posedge iCLK);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(posedge iCLK);
		#1;
		penable = 1'b1;
		// Sample mid cycle once outputs settle
		@(negedge iCLK);
		err = pslverr;
		@(posedge iCLK);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
		@(posedge iCLK);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(posedge iCLK);
		#1;
		penable = 1'b1;
		@(negedge iCLK);
		data = prdata;
		err  = pslverr;
		@(posedge iCLK);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	// Poll status until done
	task automatic wait_done();
		logic      err;
		apb_data_t st;
		st = '0;
		while (!st[1]) begin
			apb_read(`REG_STATUS, st, err);
		end
		// Done set and busy clear
		check_data("status", 32'h2, st);
	endtask

	// ==========================================================
	// Table
	// ==========================================================
	task automatic set_row(input int idx, input fp_op_e op, input fp27_t a, input fp27_t b,
		input apb_data_t exp);
		row_op[idx]  = op;
		row_a[idx]   = a;
		row_b[idx]   = b;
		row_exp[idx] = exp;
	endtask

	task automatic build_table();
		int v;
		// 1.5 + 2.25, 3 - 3, 0 + 5
		set_row(0, OP_ADD, fp_make(0, 127, 18'h20000), fp_make(0, 128, 18'h08000),
			fp_make(0, 128, 18'h38000));
		set_row(1, OP_ADD, fp_make(0, 128, 18'h20000), fp_make(1, 128, 18'h20000), 0);
		set_row(2, OP_ADD, '0, fp_make(0, 129, 18'h10000), fp_make(0, 129, 18'h10000));
		// 1.5 * 2, -2 * 0.5, zero exponent flush
		set_row(3, OP_MUL, fp_make(0, 127, 18'h20000), fp_make(0, 128, 0),
			fp_make(0, 128, 18'h20000));
		set_row(4, OP_MUL, fp_make(1, 128, 0), fp_make(0, 126, 0), fp_make(1, 127, 0));
		set_row(5, OP_MUL, fp_make(0, 0, 18'h12345), fp_make(0, 128, 0), 0);
		// Zero both ways
		set_row(6, OP_I2F, '0, '0, 0);
		set_row(7, OP_F2I, '0, '0, 0);
		// Clipping at 2^20, below one, truncation of -3.75
		set_row(8, OP_F2I, fp_make(0, 147, 0), '0, 32'h0000_7FFF);
		set_row(9, OP_F2I, fp_make(1, 147, 0), '0, 32'hFFFF_8001);
		set_row(10, OP_F2I, fp_make(0, 126, 0), '0, 0);
		set_row(11, OP_F2I, fp_make(1, 128, 18'h38000), '0, 32'hFFFF_FFFD);
		// -1 >= -2, 1 >= 2
		set_row(12, OP_CMP, fp_make(1, 127, 0), fp_make(1, 128, 0), 1);
		set_row(13, OP_CMP, fp_make(0, 127, 0), fp_make(0, 128, 0), 0);
		set_row(14, OP_NEG, fp_make(0, 128, 18'h38000), '0, fp_make(1, 128, 18'h38000));
		// Round trip pairs on integers in +-1000
		for (int i = 0; i < N_RAND; i++) begin
			lcg_state = lcg_step(lcg_state);
			v = int'(lcg_state[31:16] % 2001) - 1000;
			set_row(N_FIXED + 2 * i, OP_I2F, {11'b0, v[15:0]}, '0, int_to_fp(v));
			set_row(N_FIXED + 2 * i + 1, OP_F2I, int_to_fp(v), '0, v);
		end
	endtask

	task automatic run_row(input int idx);
		logic      err;
		apb_data_t rd;
		apb_write(`REG_OPA, {5'b0, row_a[idx]}, err);
		apb_write(`REG_OPB, {5'b0, row_b[idx]}, err);
		apb_write(`REG_CMD, {29'b0, row_op[idx]}, err);
		check_bit("pslverr", 1'b0, err);
		wait_done();
		apb_read(`REG_RESULT, rd, err);
		case (row_op[idx])
			OP_F2I: begin
				check_int("result", int16_t'(row_exp[idx][15:0]), int16_t'(rd[15:0]));
				// Upper half carries the sign extension
				check_data("result[31:16]", {16'b0, row_exp[idx][31:16]}, {16'b0, rd[31:16]});
			end
			OP_CMP:  check_bit("result", row_exp[idx][0], rd[0]);
			default: check_fp("result", row_exp[idx][`FP_W-1:0], rd[`FP_W-1:0]);
		endcase
	endtask

	// ==========================================================
	// Main sequence
	// ==========================================================
	initial begin
		logic      err;
		apb_data_t rd;
		rst_n      = 1'b0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		errors     = 0;
		pass_count = 0;
		fail_count = 0;
		lcg_state  = 32'd34;
		build_table();
		repeat (RESET_CYCLES) @(posedge iCLK);
		#1;
		rst_n = 1'b1;

		for (int i = 0; i < N_ROWS; i++) begin
			test_ok = 1'b1;
			run_row(i);
			report_test($sformatf("row %0d %s", i, row_op[i].name()));
		end

		// Command during a busy add leaves 3.75 in place
		test_ok = 1'b1;
		apb_write(`REG_OPA, {5'b0, fp_make(0, 127, 18'h20000)}, err);
		apb_write(`REG_OPB, {5'b0, fp_make(0, 128, 18'h08000)}, err);
		apb_write(`REG_CMD, {29'b0, OP_ADD}, err);
		apb_write(`REG_CMD, {29'b0, OP_MUL}, err);
		check_bit("pslverr", 1'b1, err);
		wait_done();
		apb_read(`REG_RESULT, rd, err);
		check_fp("result", fp_make(0, 128, 18'h38000), rd[`FP_W-1:0]);
		report_test("busy command");

		// Opcode 6 is undefined
		test_ok = 1'b1;
		apb_write(`REG_CMD, 32'd6, err);
		check_bit("pslverr", 1'b1, err);
		apb_read(`REG_STATUS, rd, err);
		check_data("status", 32'h2, rd);
		apb_read(`REG_RESULT, rd, err);
		check_fp("result", fp_make(0, 128, 18'h38000), rd[`FP_W-1:0]);
		report_test("bad opcode");

		// Unmapped write whose low bits match REG_CMD, then unmapped read
		test_ok = 1'b1;
		check_bit("pready", 1'b1, pready);
		apb_write(8'h28, 32'h0000_0001, err);
		check_bit("pslverr", 1'b1, err);
		apb_read(8'h14, rd, err);
		check_bit("pslverr", 1'b1, err);
		check_data("prdata", '0, rd);
		apb_read(`REG_RESULT, rd, err);
		check_fp("result", fp_make(0, 128, 18'h38000), rd[`FP_W-1:0]);
		report_test("unmapped address");

		$display("tests passed %0d failed %0d", pass_count, fail_count);
		if (fail_count == 0 && errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule
